// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - source/rv_core_pkg.sv
      - source/rv_fetch.sv
      - source/rv_decode.sv
      - source/rv_regfile.sv
      - source/rv_execute.sv
      - source/rv_mem_wb.sv
      - source/rv_core.sv
  - target: test
    files:
      - verification/rv_core_properties.sv
      - verification/rv_core_tb.sv

// ==== source/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
  input  logic                           clk,
  input  logic                           rst_n,
  output logic                           imem_ren,
  output rv_core_pkg::xlen_t             imem_raddr,
  input  rv_core_pkg::xlen_t             imem_rdata,
  output logic                           dmem_ren,
  output rv_core_pkg::xlen_t             dmem_raddr,
  input  rv_core_pkg::xlen_t             dmem_rdata,
  output logic                           dmem_we,
  output rv_core_pkg::xlen_t             dmem_waddr,
  output rv_core_pkg::xlen_t             dmem_wdata,
  output logic [rv_core_pkg::STRB_W-1:0] dmem_wstrb,
  output logic                           ebreak
);

  import rv_core_pkg::*;

  // --------------------------------------------------
  // Wires between stages
  // --------------------------------------------------
  xlen_t pc;
  logic  fetch_en;
  ctrl_t ctrl_dec;
  ctrl_t ctrl;
  xlen_t imm;
  xlen_t rs1_data;
  xlen_t rs2_data;
  xlen_t alu_result;
  xlen_t pc_plus4;
  xlen_t rd_data;
  flow_t flow;

  assign imem_ren   = fetch_en;
  assign imem_raddr = pc;

  // In reset or halt the stages get a NOP, so no writes leak out
  assign ctrl   = fetch_en ? ctrl_dec : CTRL_NOP;
  assign ebreak = rst_n && ctrl_dec.is_ebreak;

  rv_fetch u_fetch (
    .clk      (clk),
    .rst_n    (rst_n),
    .flow     (flow),
    .halt     (ctrl_dec.is_ebreak),
    .pc       (pc),
    .fetch_en (fetch_en)
  );

  rv_decode u_decode (
    .instr (imem_rdata),
    .ctrl  (ctrl_dec),
    .imm   (imm)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (ctrl.reg_write),
    .rd       (ctrl.rd),
    .rd_data  (rd_data)
  );

  rv_execute u_execute (
    .ctrl       (ctrl),
    .imm        (imm),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result),
    .pc_plus4   (pc_plus4),
    .flow       (flow)
  );

  rv_mem_wb u_mem_wb (
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .rs2_data   (rs2_data),
    .pc_plus4   (pc_plus4),
    .dmem_rdata (dmem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_we    (dmem_we),
    .dmem_raddr (dmem_raddr),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .rd_data    (rd_data)
  );

endmodule

// ==== source/rv_core_pkg.sv ====
package rv_core_pkg;

  // --------------------------------------------------
  // Widths and reset vector
  // --------------------------------------------------
  localparam int XLEN   = 32;
  localparam int REG_AW = 5;
  localparam int STRB_W = 4;

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [REG_AW-1:0] reg_idx_t;

  // First fetch address after reset
  localparam xlen_t RESET_PC = '0;

  // --------------------------------------------------
  // RV32I major opcodes
  // --------------------------------------------------
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // --------------------------------------------------
  // Control encodings
  // --------------------------------------------------
  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {ALU_A_RS1, ALU_A_PC, ALU_A_ZERO} alu_a_e;
  typedef enum logic [1:0] {RES_ALU, RES_LOAD, RES_PC4} res_src_e;
  typedef enum logic {MEM_BYTE, MEM_WORD} mem_size_e;
  typedef enum logic [1:0] {BR_EQ, BR_NE, BR_LT} br_cond_e;

  // Decoded control for one instruction
  typedef struct packed {
    logic      reg_write;
    reg_idx_t  rd;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    alu_op_e   alu_op;
    alu_a_e    alu_a;
    logic      alu_b_imm;
    res_src_e  res_src;
    logic      mem_read;
    logic      mem_write;
    mem_size_e mem_size;
    logic      mem_unsigned;
    logic      is_branch;
    br_cond_e  br_cond;
    logic      is_jal;
    logic      is_jalr;
    logic      is_ebreak;
  } ctrl_t;

  // All-zero control is a NOP: no writes, no redirect
  localparam ctrl_t CTRL_NOP = '0;

  // Redirect request from execute to fetch
  typedef struct packed {
    logic  redirect;
    xlen_t target;
  } flow_t;

endpackage

// ==== source/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
  input  rv_core_pkg::xlen_t  instr,
  output rv_core_pkg::ctrl_t  ctrl,
  output rv_core_pkg::xlen_t  imm
);

  import rv_core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  logic       valid;

  // --------------------------------------------------
  // Instruction fields
  // --------------------------------------------------
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Immediate formats, all sign-extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // --------------------------------------------------
  // Control decode
  // --------------------------------------------------
  always_comb begin
    ctrl      = CTRL_NOP;
    imm       = '0;
    valid     = 1'b1;
    ctrl.rd   = instr[11:7];
    ctrl.rs1  = instr[19:15];
    ctrl.rs2  = instr[24:20];

    case (opcode)
      OP_LUI: begin
        // Immediate passes straight through the ALU
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.alu_b_imm = 1'b1;
        imm            = imm_u;
      end
      OP_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_a     = ALU_A_PC;
        ctrl.alu_b_imm = 1'b1;
        imm            = imm_u;
      end
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        imm            = imm_i;
        case (funct3)
          3'b000:  ctrl.alu_op = ALU_ADD;
          3'b010:  ctrl.alu_op = ALU_SLT;
          3'b100:  ctrl.alu_op = ALU_XOR;
          3'b110:  ctrl.alu_op = ALU_OR;
          3'b111:  ctrl.alu_op = ALU_AND;
          // Shifts and SLTIU not supported
          default: valid = 1'b0;
        endcase
      end
      OP_REG: begin
        ctrl.reg_write = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: ctrl.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: ctrl.alu_op = ALU_SUB;
          {7'b0000000, 3'b010}: ctrl.alu_op = ALU_SLT;
          {7'b0000000, 3'b011}: ctrl.alu_op = ALU_SLTU;
          {7'b0000000, 3'b100}: ctrl.alu_op = ALU_XOR;
          {7'b0000000, 3'b110}: ctrl.alu_op = ALU_OR;
          {7'b0000000, 3'b111}: ctrl.alu_op = ALU_AND;
          default:              valid = 1'b0;
        endcase
      end
      OP_LOAD: begin
        // LB, LBU, LW
        ctrl.reg_write    = 1'b1;
        ctrl.mem_read     = 1'b1;
        ctrl.res_src      = RES_LOAD;
        ctrl.alu_b_imm    = 1'b1;
        ctrl.mem_size     = (funct3 == 3'b010) ? MEM_WORD : MEM_BYTE;
        ctrl.mem_unsigned = (funct3 == 3'b100);
        imm               = imm_i;
        valid = (funct3 == 3'b000) || (funct3 == 3'b100) || (funct3 == 3'b010);
      end
      OP_STORE: begin
        // SB, SW
        ctrl.mem_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.mem_size  = (funct3 == 3'b010) ? MEM_WORD : MEM_BYTE;
        imm            = imm_s;
        valid          = (funct3 == 3'b000) || (funct3 == 3'b010);
      end
      OP_BRANCH: begin
        ctrl.is_branch = 1'b1;
        imm            = imm_b;
        case (funct3)
          3'b000:  ctrl.br_cond = BR_EQ;
          3'b001:  ctrl.br_cond = BR_NE;
          3'b100:  ctrl.br_cond = BR_LT;
          default: valid = 1'b0;
        endcase
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.res_src   = RES_PC4;
        ctrl.is_jal    = 1'b1;
        imm            = imm_j;
      end
      OP_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.res_src   = RES_PC4;
        ctrl.is_jalr   = 1'b1;
        imm            = imm_i;
        valid          = (funct3 == 3'b000);
      end
      OP_SYSTEM: begin
        // Only EBREAK, exact encoding
        ctrl.is_ebreak = (instr == 32'h0010_0073);
        valid          = ctrl.is_ebreak;
      end
      default: valid = 1'b0;
    endcase

    // Unsupported encodings fall back to NOP
    if (!valid) begin
      ctrl = CTRL_NOP;
      imm  = '0;
    end
  end

endmodule

// ==== source/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
  input  rv_core_pkg::ctrl_t ctrl,
  input  rv_core_pkg::xlen_t imm,
  input  rv_core_pkg::xlen_t pc,
  input  rv_core_pkg::xlen_t rs1_data,
  input  rv_core_pkg::xlen_t rs2_data,
  output rv_core_pkg::xlen_t alu_result,
  output rv_core_pkg::xlen_t pc_plus4,
  output rv_core_pkg::flow_t flow
);

  import rv_core_pkg::*;

  xlen_t op_a;
  xlen_t op_b;
  xlen_t jalr_sum;
  logic  br_taken;

  // --------------------------------------------------
  // Operand select
  // --------------------------------------------------
  always_comb begin
    case (ctrl.alu_a)
      ALU_A_PC:   op_a = pc;
      ALU_A_ZERO: op_a = '0;
      default:    op_a = rs1_data;
    endcase
  end

  assign op_b = ctrl.alu_b_imm ? imm : rs2_data;

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------
  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_OR:     alu_result = op_a | op_b;
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SLT:    alu_result = XLEN'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   alu_result = XLEN'(op_a < op_b);
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // --------------------------------------------------
  // Branch compare, always on the register values
  // --------------------------------------------------
  always_comb begin
    case (ctrl.br_cond)
      BR_EQ:   br_taken = (rs1_data == rs2_data);
      BR_NE:   br_taken = (rs1_data != rs2_data);
      BR_LT:   br_taken = ($signed(rs1_data) < $signed(rs2_data));
      default: br_taken = 1'b0;
    endcase
  end

  // --------------------------------------------------
  // Redirect
  // --------------------------------------------------
  assign pc_plus4 = pc + XLEN'(4);
  assign jalr_sum = rs1_data + imm;

  assign flow.redirect = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && br_taken);

  // JALR target drops bit 0, others are PC relative
  assign flow.target = ctrl.is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : pc + imm;

endmodule

// ==== source/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch (
  input  logic               clk,
  input  logic               rst_n,
  input  rv_core_pkg::flow_t flow,
  input  logic               halt,
  output rv_core_pkg::xlen_t pc,
  output logic               fetch_en
);

  import rv_core_pkg::*;

  xlen_t pc_next;

  // --------------------------------------------------
  // Next PC
  // --------------------------------------------------
  always_comb begin
    // Taken branch or jump wins over sequential
    if (flow.redirect) begin
      pc_next = flow.target;
    end else begin
      pc_next = pc + XLEN'(4);
    end
  end

  // --------------------------------------------------
  // PC register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!halt) begin
      pc <= pc_next;
    end
    // Halted on EBREAK, pc frozen until reset
  end

  // Stages see a NOP while in reset or halted
  assign fetch_en = rst_n && !halt;

endmodule

// ==== source/rv_mem_wb.sv ====
`timescale 1ns/1ps

module rv_mem_wb (
  input  rv_core_pkg::ctrl_t               ctrl,
  input  rv_core_pkg::xlen_t               alu_result,
  input  rv_core_pkg::xlen_t               rs2_data,
  input  rv_core_pkg::xlen_t               pc_plus4,
  input  rv_core_pkg::xlen_t               dmem_rdata,
  output logic                             dmem_ren,
  output logic                             dmem_we,
  output rv_core_pkg::xlen_t               dmem_raddr,
  output rv_core_pkg::xlen_t               dmem_waddr,
  output rv_core_pkg::xlen_t               dmem_wdata,
  output logic [rv_core_pkg::STRB_W-1:0]   dmem_wstrb,
  output rv_core_pkg::xlen_t               rd_data
);

  import rv_core_pkg::*;

  xlen_t      addr_word;
  logic [1:0] lane;
  logic [7:0] load_byte;
  xlen_t      load_val;

  // Unaligned word access just ignores the low bits
  assign addr_word = {alu_result[XLEN-1:2], 2'b00};
  assign lane      = alu_result[1:0];

  // --------------------------------------------------
  // Store side
  // --------------------------------------------------
  assign dmem_we    = ctrl.mem_write;
  assign dmem_waddr = addr_word;

  // SB copies the byte to every lane, strobe picks one
  assign dmem_wdata = (ctrl.mem_size == MEM_BYTE) ? {STRB_W{rs2_data[7:0]}} : rs2_data;
  assign dmem_wstrb = (ctrl.mem_size == MEM_BYTE) ? (STRB_W'(1) << lane) : '1;

  // --------------------------------------------------
  // Load side
  // --------------------------------------------------
  assign dmem_ren   = ctrl.mem_read;
  assign dmem_raddr = addr_word;
  assign load_byte  = dmem_rdata[lane*8 +: 8];

  // LBU zero fills, LB copies bit 7
  assign load_val = (ctrl.mem_size == MEM_WORD) ? dmem_rdata :
                    {{(XLEN-8){!ctrl.mem_unsigned && load_byte[7]}}, load_byte};

  // --------------------------------------------------
  // Write-back select
  // --------------------------------------------------
  always_comb begin
    case (ctrl.res_src)
      RES_LOAD: rd_data = load_val;
      RES_PC4:  rd_data = pc_plus4;
      default:  rd_data = alu_result;
    endcase
  end

endmodule

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_core_pkg::reg_idx_t rs1,
  input  rv_core_pkg::reg_idx_t rs2,
  output rv_core_pkg::xlen_t    rs1_data,
  output rv_core_pkg::xlen_t    rs2_data,
  input  logic                  we,
  input  rv_core_pkg::reg_idx_t rd,
  input  rv_core_pkg::xlen_t    rd_data
);

  import rv_core_pkg::*;

  localparam int NREGS = 2 ** REG_AW;

  // x1..x31 only, x0 has no storage
  xlen_t regs [1:NREGS-1];

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // --------------------------------------------------
  // Read ports, x0 reads zero
  // --------------------------------------------------
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== sources.f ====
source/rv_core_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_mem_wb.sv
source/rv_core.sv
verification/rv_core_properties.sv
verification/rv_core_tb.sv

// ==== verification/rv_core_properties.sv ====
`timescale 1ns/1ps

module rv_core_properties (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           dmem_we,
  input logic [rv_core_pkg::STRB_W-1:0] dmem_wstrb,
  input logic                           ebreak,
  input rv_core_pkg::xlen_t             imem_raddr
);

  // --------------------------------------------------
  // Store side
  // --------------------------------------------------
  // A store must touch at least one lane
  a_strobe_set: assert property (@(posedge clk) dmem_we |-> (dmem_wstrb != '0))
    else $error("Store issued with an empty byte strobe");

  a_no_store_in_reset: assert property (@(posedge clk) !rst_n |-> !dmem_we)
    else $error("Store issued while reset is asserted");

  // --------------------------------------------------
  // Halt and fetch
  // --------------------------------------------------
  a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n) ebreak |-> !dmem_we)
    else $error("Store issued while halted on EBREAK");

  // Halt holds until the next reset
  a_halt_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ebreak |=> (ebreak && $stable(imem_raddr)))
    else $error("Fetch address moved or ebreak dropped after halt");

  a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    imem_raddr[1:0] == 2'b00)
    else $error("Fetch address is not word aligned");

endmodule

bind rv_core rv_core_properties u_properties (
  .clk        (clk),
  .rst_n      (rst_n),
  .dmem_we    (dmem_we),
  .dmem_wstrb (dmem_wstrb),
  .ebreak     (ebreak),
  .imem_raddr (imem_raddr)
);

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

  import rv_core_pkg::*;

  // --------------------------------------------------
  // Table size and run limits
  // --------------------------------------------------
  localparam int N_TESTS       = 5;
  localparam int PROG_WORDS    = 16;
  localparam int MEM_WORDS     = 256;
  localparam int RESET_CYCLES  = 4;
  localparam int RUN_LIMIT     = 64;
  localparam int SETTLE_CYCLES = 2;
  // Per test one lead-in edge, reset, run and settle
  localparam int CYCLE_LIMIT   = N_TESTS * (RESET_CYCLES + RUN_LIMIT + SETTLE_CYCLES + 1) + 1;

  // Major opcodes straight from the ISA manual
  localparam logic [6:0] OPC_LUI  = 7'h37;
  localparam logic [6:0] OPC_IMM  = 7'h13;
  localparam logic [6:0] OPC_LOAD = 7'h03;
  localparam logic [6:0] OPC_JALR = 7'h67;
  localparam xlen_t EBREAK_WORD   = 32'h0010_0073;

  // Init word at address 0, address checked, word expected there
  typedef struct packed {
    xlen_t init_word;
    xlen_t check_addr;
    xlen_t expect_word;
  } entry_t;

  logic                clk;
  logic                rst_n;
  logic                imem_ren;
  xlen_t               imem_raddr;
  xlen_t               imem_rdata;
  logic                dmem_ren;
  xlen_t               dmem_raddr;
  xlen_t               dmem_rdata;
  logic                dmem_we;
  xlen_t               dmem_waddr;
  xlen_t               dmem_wdata;
  logic [STRB_W-1:0]   dmem_wstrb;
  logic                ebreak;

  xlen_t  imem [MEM_WORDS];
  xlen_t  dmem [MEM_WORDS];
  string  test_name [N_TESTS];
  xlen_t  prog [N_TESTS][PROG_WORDS];
  entry_t expect_tab [N_TESTS];
  int     cycle_count = 0;

  rv_core u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .ebreak     (ebreak)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // --------------------------------------------------
  // Memory models
  // --------------------------------------------------
  assign imem_rdata = imem[imem_raddr[9:2]];
  // Data port only answers a read request
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[9:2]] : 'x;

  // Byte-masked write at the edge
  always @(posedge clk) begin
    if (dmem_we) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (dmem_wstrb[b]) begin
          dmem[dmem_waddr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
        end
      end
    end
  end

  // Global watchdog
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      stop_on_failure($sformatf("Simulation ran past its limit of %0d cycles", CYCLE_LIMIT));
    end
  end

  // --------------------------------------------------
  // Instruction encoders
  // --------------------------------------------------
  function automatic xlen_t i_type(input logic [6:0] op, input logic [2:0] f3,
                                   input logic [4:0] rd, input logic [4:0] rs1,
                                   input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic xlen_t r_type(input logic [2:0] f3, input logic [6:0] f7,
                                   input logic [4:0] rd, input logic [4:0] rs1,
                                   input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic xlen_t s_type(input logic [2:0] f3, input logic [4:0] rs1,
                                   input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  // Offset is in bytes, bit 0 dropped by the format
  function automatic xlen_t b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                   input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic xlen_t u_type(input logic [6:0] op, input logic [4:0] rd,
                                   input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic xlen_t j_type(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // ADDI x0 with the word index as immediate
  function automatic xlen_t nop_at(input int idx);
    return i_type(OPC_IMM, 3'b000, 5'd0, 5'd0, idx[11:0]);
  endfunction

  // --------------------------------------------------
  // Test table
  // --------------------------------------------------
  task automatic build_table();
    for (int t = 0; t < N_TESTS; t++) begin
      for (int k = 0; k < PROG_WORDS; k++) begin
        prog[t][k] = nop_at(k);
      end
    end
    // 0x12345678, -3, then all R-type ops folded into one word
    // SLT result is added and SLTU result subtracted
    test_name[0]  = "alu";
    prog[0][0]    = u_type(OPC_LUI, 1, 20'h12345);
    prog[0][1]    = i_type(OPC_IMM, 3'b000, 1, 1, 12'h678);
    prog[0][2]    = i_type(OPC_IMM, 3'b000, 2, 0, 12'hffd);
    prog[0][3]    = r_type(3'b000, 7'h00, 3, 1, 2);
    prog[0][4]    = r_type(3'b000, 7'h20, 4, 1, 3);
    prog[0][5]    = r_type(3'b100, 7'h00, 5, 3, 1);
    prog[0][6]    = u_type(OPC_LUI, 9, 20'hffff0);
    prog[0][7]    = r_type(3'b111, 7'h00, 10, 1, 9);
    prog[0][8]    = r_type(3'b110, 7'h00, 10, 10, 5);
    prog[0][9]    = r_type(3'b010, 7'h00, 6, 2, 4);
    prog[0][10]   = r_type(3'b011, 7'h00, 7, 2, 4);
    prog[0][11]   = r_type(3'b000, 7'h00, 10, 10, 6);
    prog[0][12]   = r_type(3'b000, 7'h20, 10, 10, 7);
    prog[0][13]   = r_type(3'b000, 7'h00, 10, 10, 4);
    prog[0][14]   = s_type(3'b010, 0, 10, 12'h010);
    prog[0][15]   = EBREAK_WORD;
    expect_tab[0] = {32'h0000_0000, 32'h0000_0010, 32'h1234_0011};
    // SB 0x7e into byte 2, LB and LBU of byte 3 (0x91)
    test_name[1]  = "byte";
    prog[1][0]    = i_type(OPC_IMM, 3'b000, 1, 0, 12'h07e);
    prog[1][1]    = s_type(3'b000, 0, 1, 12'h002);
    prog[1][2]    = i_type(OPC_LOAD, 3'b000, 2, 0, 12'h003);
    prog[1][3]    = i_type(OPC_LOAD, 3'b100, 3, 0, 12'h003);
    prog[1][4]    = s_type(3'b010, 0, 2, 12'h004);
    prog[1][5]    = s_type(3'b010, 0, 3, 12'h008);
    prog[1][6]    = i_type(OPC_LOAD, 3'b010, 4, 0, 12'h000);
    prog[1][7]    = i_type(OPC_LOAD, 3'b010, 7, 0, 12'h004);
    prog[1][8]    = i_type(OPC_LOAD, 3'b010, 8, 0, 12'h008);
    prog[1][9]    = r_type(3'b100, 7'h00, 5, 7, 8);
    prog[1][10]   = r_type(3'b000, 7'h00, 6, 4, 5);
    prog[1][11]   = s_type(3'b010, 0, 6, 12'h010);
    prog[1][12]   = EBREAK_WORD;
    expect_tab[1] = {32'h9122_3344, 32'h0000_0010, 32'h917e_3244};
    // BNE loop to 5, then BEQ jumps over a store of zero
    test_name[2]  = "branch";
    prog[2][0]    = i_type(OPC_IMM, 3'b000, 1, 0, 12'h000);
    prog[2][1]    = i_type(OPC_IMM, 3'b000, 2, 0, 12'h005);
    prog[2][2]    = i_type(OPC_IMM, 3'b000, 1, 1, 12'h001);
    prog[2][3]    = b_type(3'b001, 1, 2, 13'h1ffc);
    prog[2][4]    = s_type(3'b010, 0, 1, 12'h010);
    prog[2][5]    = b_type(3'b000, 1, 2, 13'h0008);
    prog[2][6]    = s_type(3'b010, 0, 0, 12'h010);
    prog[2][7]    = EBREAK_WORD;
    expect_tab[2] = {32'h0000_0000, 32'h0000_0010, 32'h0000_0005};
    // Call at 0 links 4, JALR with odd offset returns to 4 and links 0x1c
    test_name[3]  = "jump";
    prog[3][0]    = j_type(1, 21'd20);
    prog[3][1]    = r_type(3'b110, 7'h00, 4, 1, 3);
    prog[3][2]    = r_type(3'b000, 7'h00, 4, 4, 6);
    prog[3][3]    = s_type(3'b010, 0, 4, 12'h010);
    prog[3][4]    = EBREAK_WORD;
    prog[3][5]    = i_type(OPC_IMM, 3'b000, 3, 0, 12'h700);
    prog[3][6]    = i_type(OPC_JALR, 3'b000, 6, 1, 12'h001);
    expect_tab[3] = {32'h0000_0000, 32'h0000_0010, 32'h0000_0720};
    // Store after EBREAK would overwrite the zero
    test_name[4]  = "halt";
    prog[4][0]    = i_type(OPC_IMM, 3'b000, 0, 0, 12'h123);
    prog[4][1]    = s_type(3'b010, 0, 0, 12'h010);
    prog[4][2]    = i_type(OPC_IMM, 3'b000, 1, 0, 12'h055);
    prog[4][3]    = EBREAK_WORD;
    prog[4][4]    = s_type(3'b010, 0, 1, 12'h010);
    expect_tab[4] = {32'h0000_0000, 32'h0000_0010, 32'h0000_0000};
  endtask

  // --------------------------------------------------
  // Run helpers
  // --------------------------------------------------
  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
    if (actual !== expected) begin
      stop_on_failure($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // Data words get an address-dependent fill before the init word
  task automatic load_memories(input int t);
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = nop_at(i);
      dmem[i] <= {8'ha5, i[7:0], ~i[7:0], i[7:0]};
    end
    for (int k = 0; k < PROG_WORDS; k++) begin
      imem[k] = prog[t][k];
    end
    dmem[0] <= expect_tab[t].init_word;
  endtask

  task automatic run_test(input int t);
    int    cycles;
    xlen_t addr;
    xlen_t got;
    @(negedge clk);
    rst_n = 1'b0;
    load_memories(t);
    repeat (RESET_CYCLES) @(negedge clk);
    // No fetch or load request while in reset
    check_value({test_name[t], " reset imem_ren"}, 32'd0, {31'd0, imem_ren});
    check_value({test_name[t], " reset dmem_ren"}, 32'd0, {31'd0, dmem_ren});
    rst_n = 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      // Fetch stays enabled while running
      if (!ebreak) begin
        check_value({test_name[t], " imem_ren"}, 32'd1, {31'd0, imem_ren});
      end
    end while (!ebreak && cycles < RUN_LIMIT);
    if (!ebreak) begin
      stop_on_failure($sformatf("Test %s did not reach EBREAK within %0d cycles",
                                test_name[t], RUN_LIMIT));
    end
    // Halt must hold a few cycles
    repeat (SETTLE_CYCLES) @(negedge clk);
    check_value({test_name[t], " ebreak"}, 32'd1, {31'd0, ebreak});
    check_value({test_name[t], " halt imem_ren"}, 32'd0, {31'd0, imem_ren});
    addr = expect_tab[t].check_addr;
    got  = dmem[addr[9:2]];
    check_value(test_name[t], expect_tab[t].expect_word, got);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    rst_n = 1'b0;
    build_table();
    load_memories(0);
    for (int t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule
